//--- design/adcfifo_config.svh
`ifndef ADCFIFO_CONFIG_SVH
`define ADCFIFO_CONFIG_SVH

// host register map, 8-bit addresses
`define ADCREAD_ADDR              8'h03  // sample byte stream
`define ADC_LOW_RES               8'h20  // bit0 low_res, bit1 lsb select
`define STREAM_SEGMENT_THRESHOLD  8'h21  // 17-bit, three byte lanes
`define FIFO_STAT                 8'h22  // rd {empty, errors}; wr bit0 clears errors
`define FIFO_FIRST_ERROR          8'h23  // frozen first error word
`define FIFO_FIRST_ERROR_STATE    8'h24  // fill level msbs at first error
`define FIFO_UNDERFLOW_COUNT      8'h25  // saturating
`define FIFO_NO_UNDERFLOW_ERROR   8'h26  // mask slow-mode underflow
`define CAPTURE_DONE              8'h27  // segment complete
`define FAST_FIFO_READ_MODE       8'h28  // self-clearing on other writes
`define DEBUG_FIFO_READS          8'h29  // 32-bit pop count
`define DEBUG_FIFO_READS_FREEZE   8'h2A  // pop count at first error

// sizes
`define ADC_FIFO_DEPTH            64     // words, power of two
`define BYTECNT_SIZE              7      // width of reg_bytecnt

// reset values
`define THRESHOLD_RESET           65536  // fits in 17 bits

`endif

//--- design/adcfifo_pkg.sv
`default_nettype none

package adcfifo_pkg;

  // one full-resolution sample per word
  typedef struct packed {
    logic [5:0] pad;     // always zero
    logic [9:0] sample;  // raw adc code
  } adc_full_t;

  // two truncated samples per word
  typedef struct packed {
    logic [7:0] second;  // later sample, upper byte
    logic [7:0] first;   // earlier sample, lower byte
  } adc_pair_t;

  // fifo word, decoded by low_res
  typedef union packed {
    adc_full_t full;     // low_res = 0
    adc_pair_t pair;     // low_res = 1
  } adc_word_u;

endpackage

`default_nettype wire

//--- design/adcfifo_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "adcfifo_config.svh"

module adcfifo_regs (
  input  wire                     clk_usb,
  input  wire                     reset,
  input  wire [7:0]               reg_address,                   // register select
  input  wire [`BYTECNT_SIZE-1:0] reg_bytecnt,                   // byte lane
  input  wire [7:0]               reg_datai,                     // write data
  output logic [7:0]              reg_datao,                     // zero outside reads
  input  wire                     reg_read,                      // level, held per byte
  input  wire                     reg_write,                     // acts at this edge
  input  wire [7:0]               read_byte,                     // from formatter
  input  wire                     fifo_empty,
  input  wire [8:0]               fifo_error_stat,
  input  wire [8:0]               fifo_first_error_stat,
  input  wire [2:0]               fifo_first_error_state,
  input  wire [7:0]               underflow_count,
  input  wire                     capture_done,
  input  wire [31:0]              fifo_read_count,
  input  wire [31:0]              fifo_read_count_error_freeze,
  output logic                    fifo_rd_en,                    // one-cycle advance
  output logic                    low_res,
  output logic                    low_res_lsb,
  output logic                    fast_fifo_read_mode,
  output logic [16:0]             stream_segment_threshold,
  output logic                    clear_fifo_errors,             // level, as written
  output logic                    no_underflow_errors
);

  logic        reg_read_r;   // read strobe, last cycle
  logic        read_rise;    // first cycle of a stream read
  logic        rd_en_slow;   // registered advance
  logic        lane_ok;      // bytecnt within 0..3
  logic [1:0]  lane;
  logic [31:0] rd_word;      // addressed register, zero-extended

  assign lane    = reg_bytecnt[1:0];
  assign lane_ok = (reg_bytecnt[`BYTECNT_SIZE-1:2] == '0);

  // register select for readback
  always_comb begin
    rd_word = '0;
    case (reg_address)
      `FIFO_STAT:                rd_word = {22'd0, fifo_empty, fifo_error_stat};
      `FIFO_FIRST_ERROR:         rd_word = {23'd0, fifo_first_error_stat};
      `FIFO_FIRST_ERROR_STATE:   rd_word = {29'd0, fifo_first_error_state};
      `DEBUG_FIFO_READS:         rd_word = fifo_read_count;
      `DEBUG_FIFO_READS_FREEZE:  rd_word = fifo_read_count_error_freeze;
      `STREAM_SEGMENT_THRESHOLD: rd_word = {15'd0, stream_segment_threshold};
      `ADC_LOW_RES:              rd_word = {30'd0, low_res_lsb, low_res};
      `FIFO_UNDERFLOW_COUNT:     rd_word = {24'd0, underflow_count};
      `FIFO_NO_UNDERFLOW_ERROR:  rd_word = {31'd0, no_underflow_errors};
      `CAPTURE_DONE:             rd_word = {31'd0, capture_done};
      `FAST_FIFO_READ_MODE:      rd_word = {31'd0, fast_fifo_read_mode};
      default:                   rd_word = '0;
    endcase
  end

  // byte out; stream reads ignore bytecnt
  always_comb begin
    if (!reg_read) begin
      reg_datao = 8'h00;
    end else if (reg_address == `ADCREAD_ADDR) begin
      reg_datao = read_byte;
    end else if (lane_ok) begin
      reg_datao = rd_word[lane*8 +: 8];
    end else begin
      reg_datao = 8'h00;
    end
  end

  // control registers
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res                  <= 1'b0;
      low_res_lsb              <= 1'b0;
      clear_fifo_errors        <= 1'b0;
      no_underflow_errors      <= 1'b0;
      stream_segment_threshold <= 17'(`THRESHOLD_RESET);
    end else if (reg_write) begin
      case (reg_address)
        `ADC_LOW_RES: begin
          low_res     <= reg_datai[0];
          low_res_lsb <= reg_datai[1];                           // 1 = bits 7..0
        end
        `STREAM_SEGMENT_THRESHOLD: begin
          case (reg_bytecnt)
            'd0:     stream_segment_threshold[7:0]  <= reg_datai;
            'd1:     stream_segment_threshold[15:8] <= reg_datai;
            'd2:     stream_segment_threshold[16]   <= reg_datai[0];
            default: ;                                           // no such lane
          endcase
        end
        `FIFO_STAT:               clear_fifo_errors   <= reg_datai[0];
        `FIFO_NO_UNDERFLOW_ERROR: no_underflow_errors <= reg_datai[0];
        default: ;
      endcase
    end
  end

  // fast mode drops out on any other register write
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fast_fifo_read_mode <= 1'b0;
    end else if (reg_write) begin
      if (reg_address == `FAST_FIFO_READ_MODE) begin
        fast_fifo_read_mode <= reg_datai[0];
      end else begin
        fast_fifo_read_mode <= 1'b0;
      end
    end
  end

  assign read_rise = reg_read && !reg_read_r && (reg_address == `ADCREAD_ADDR);

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_read_r <= 1'b0;
      rd_en_slow <= 1'b0;
    end else begin
      reg_read_r <= reg_read;
      rd_en_slow <= read_rise && !fast_fifo_read_mode;           // slow path, one late
    end
  end

  // fast mode advances in the read cycle itself
  assign fifo_rd_en = fast_fifo_read_mode ? read_rise : rd_en_slow;

  // every stream read edge gets its advance, also across a mode change
  a_rd_en_per_read: assert property (@(posedge clk_usb) disable iff (reset)
    read_rise && !fifo_rd_en |=> fifo_rd_en)
    else $error("stream read edge produced no fifo advance");

endmodule

`default_nettype wire

//--- design/adc_sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "adcfifo_config.svh"

module adc_sample_fifo
  import adcfifo_pkg::*;
(
  input  wire         clk_usb,
  input  wire         reset,
  input  wire  [9:0]  adc_sample,
  input  wire         sample_valid,
  input  wire         low_res,
  input  wire         low_res_lsb,
  input  wire         fast_fifo_read_mode,
  input  wire         no_underflow_errors,
  input  wire  [16:0] stream_segment_threshold,
  input  wire         clear_fifo_errors,                 // also rearms capture
  input  wire         fifo_pop,
  output adc_word_u   fifo_word,                         // show-ahead head
  output logic        fifo_empty,
  output logic [8:0]  fifo_error_stat,                   // bit0 overflow, bit1 underflow
  output logic [8:0]  fifo_first_error_stat,
  output logic [2:0]  fifo_first_error_state,
  output logic [7:0]  underflow_count,
  output logic        capture_done,
  output logic [31:0] fifo_read_count,
  output logic [31:0] fifo_read_count_error_freeze
);

  localparam int DEPTH = `ADC_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  adc_word_u     mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;                                   // 0..DEPTH
  logic          fifo_full;
  logic [16:0]   sample_count;                           // accepted samples
  logic          half_full;                              // first byte of a pair held
  logic [7:0]    half_byte;
  logic [7:0]    lr_byte;                                // truncated sample
  logic          take;
  logic          word_done;
  logic          push;
  logic          pop_ok;
  logic          overflow_hit;
  logic          underflow_hit;
  logic [1:0]    err_flags;
  logic [1:0]    err_next;
  adc_word_u     in_word;

  assign lr_byte   = low_res_lsb ? adc_sample[7:0] : adc_sample[9:2];
  assign take      = sample_valid && !capture_done;      // ignored once segment ends
  assign word_done = take && (!low_res || half_full);
  assign fifo_full = (fill == (AW+1)'(DEPTH));
  assign fifo_empty = (fill == '0);
  assign push      = word_done && !fifo_full;
  assign pop_ok    = fifo_pop && !fifo_empty;
  assign overflow_hit  = word_done && fifo_full;         // sample dropped
  assign underflow_hit = fifo_pop && fifo_empty && (fast_fifo_read_mode || !no_underflow_errors);

  always_comb begin
    if (low_res) begin
      in_word.pair.first  = half_byte;
      in_word.pair.second = lr_byte;
    end else begin
      in_word.full.pad    = '0;
      in_word.full.sample = adc_sample;
    end
  end

  // segment length and pair packing
  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      sample_count <= '0;
      capture_done <= 1'b0;
      half_full    <= 1'b0;
    end else if (take) begin
      sample_count <= sample_count + 17'd1;
      if (sample_count + 17'd1 >= stream_segment_threshold) capture_done <= 1'b1;
      if (low_res) half_full <= !half_full;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (take && low_res && !half_full) half_byte <= lr_byte;
  end

  always_ff @(posedge clk_usb) begin
    if (push) mem[wr_ptr] <= in_word;
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      fill <= fill + (AW+1)'(push) - (AW+1)'(pop_ok);
    end
  end

  assign fifo_word = mem[rd_ptr];

  // sticky errors, first one frozen with fill msbs and pop count
  assign err_next = err_flags | {underflow_hit, overflow_hit};

  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      err_flags                    <= '0;
      fifo_first_error_stat        <= '0;
      fifo_first_error_state       <= '0;
      fifo_read_count_error_freeze <= '0;
    end else begin
      err_flags <= err_next;
      if (fifo_first_error_stat == 9'd0 && err_next != 2'b00) begin
        fifo_first_error_stat        <= {7'd0, err_next};
        fifo_first_error_state       <= fill[AW -: 3];
        fifo_read_count_error_freeze <= fifo_read_count;
      end
    end
  end

  assign fifo_error_stat = {7'd0, err_flags};

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      underflow_count <= '0;
      fifo_read_count <= '0;
    end else begin
      if (underflow_hit && underflow_count != 8'hFF) underflow_count <= underflow_count + 8'd1;
      if (fifo_pop) fifo_read_count <= fifo_read_count + 32'd1;   // every pop request
    end
  end

  a_fill_bound: assert property (@(posedge clk_usb) disable iff (reset)
    fill <= (AW+1)'(DEPTH))
    else $error("fifo fill level above depth");

endmodule

`default_nettype wire

//--- design/adc_read_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module adc_read_formatter
  import adcfifo_pkg::*;
(
  input  wire            clk_usb,
  input  wire            reset,
  input  wire adc_word_u fifo_word,      // head of fifo
  input  wire            low_res,        // selects word view
  input  wire            fifo_rd_en,     // host advance
  output logic [7:0]     read_byte,
  output logic           fifo_pop        // with second advance
);

  logic       phase;                     // 0 lower byte, 1 upper byte
  logic [7:0] lo_byte;
  logic [7:0] hi_byte;

  // decode the head word per mode
  always_comb begin
    lo_byte = fifo_word.pair.first;                          // earlier sample or bits 7..0
    if (low_res) begin
      hi_byte = fifo_word.pair.second;
    end else begin
      hi_byte = {6'd0, fifo_word.full.sample[9:8]};          // top two bits only
    end
  end

  assign read_byte = phase ? hi_byte : lo_byte;

  // head moves at the same edge the phase wraps
  assign fifo_pop = fifo_rd_en && phase;

  // mode changes only happen with the fifo drained, phase kept
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      phase <= 1'b0;
    end else if (fifo_rd_en) begin
      phase <= !phase;
    end
  end

endmodule

`default_nettype wire

//--- design/openadc_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "adcfifo_config.svh"

module openadc_fifo_top
  import adcfifo_pkg::*;
(
  input  wire                     clk_usb,
  input  wire                     reset,
  input  wire [7:0]               reg_address,
  input  wire [`BYTECNT_SIZE-1:0] reg_bytecnt,
  input  wire [7:0]               reg_datai,
  output wire [7:0]               reg_datao,
  input  wire                     reg_read,
  input  wire                     reg_write,
  input  wire [9:0]               adc_sample,    // already on clk_usb
  input  wire                     sample_valid
);

  wire            fifo_rd_en;
  wire            fifo_pop;
  wire [7:0]      read_byte;
  wire adc_word_u fifo_word;
  wire            fifo_empty;
  wire            low_res;
  wire            low_res_lsb;
  wire            fast_fifo_read_mode;
  wire [16:0]     stream_segment_threshold;
  wire            clear_fifo_errors;
  wire            no_underflow_errors;
  wire [8:0]      fifo_error_stat;
  wire [8:0]      fifo_first_error_stat;
  wire [2:0]      fifo_first_error_state;
  wire [7:0]      underflow_count;
  wire            capture_done;
  wire [31:0]     fifo_read_count;
  wire [31:0]     fifo_read_count_error_freeze;

  // host registers
  adcfifo_regs regs_i (
    .clk_usb, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
    .reg_read, .reg_write, .read_byte, .fifo_empty, .fifo_error_stat,
    .fifo_first_error_stat, .fifo_first_error_state, .underflow_count,
    .capture_done, .fifo_read_count, .fifo_read_count_error_freeze,
    .fifo_rd_en, .low_res, .low_res_lsb, .fast_fifo_read_mode,
    .stream_segment_threshold, .clear_fifo_errors, .no_underflow_errors
  );

  // sample storage
  adc_sample_fifo fifo_i (
    .clk_usb, .reset, .adc_sample, .sample_valid, .low_res, .low_res_lsb,
    .fast_fifo_read_mode, .no_underflow_errors, .stream_segment_threshold,
    .clear_fifo_errors, .fifo_pop, .fifo_word, .fifo_empty, .fifo_error_stat,
    .fifo_first_error_stat, .fifo_first_error_state, .underflow_count,
    .capture_done, .fifo_read_count, .fifo_read_count_error_freeze
  );

  // word to byte stream
  adc_read_formatter fmt_i (
    .clk_usb, .reset, .fifo_word, .low_res, .fifo_rd_en, .read_byte, .fifo_pop
  );

endmodule

`default_nettype wire

//--- bench/adcfifo_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "adcfifo_config.svh"

module adcfifo_checker (
  input  wire                     clk_usb,
  input  wire                     reset,
  input  wire [7:0]               reg_address,
  input  wire [`BYTECNT_SIZE-1:0] reg_bytecnt,
  input  wire [7:0]               reg_datai,
  input  wire [7:0]               reg_datao,
  input  wire                     reg_read,
  input  wire                     reg_write,
  input  wire [9:0]               adc_sample,
  input  wire                     sample_valid,
  input  wire [1:0]               chk_mode,       // 1 table byte, 2 model stream
  input  wire [7:0]               exp_byte,
  output int                      value_errors,
  output int                      other_errors
);

  logic [7:0]  stream_q [$];                      // bytes the host should see
  logic        low_res_m;
  logic        lsb_m;
  logic        half_m;                            // first byte of a pair held
  logic        done_m;
  logic [7:0]  pend_m;
  logic [16:0] thr_m;
  logic [16:0] count_m;

  initial begin
    value_errors = 0;
    other_errors = 0;
  end

  function automatic logic [7:0] low_res_byte(input logic [9:0] s, input logic lsb);
    return lsb ? s[7:0] : s[9:2];
  endfunction

  // word dropped when the fifo already holds its depth
  task automatic store_word(input logic [7:0] lo, input logic [7:0] hi);
    if ((stream_q.size() + 1) / 2 < `ADC_FIFO_DEPTH) begin
      stream_q.push_back(lo);
      stream_q.push_back(hi);
    end
  endtask

  task automatic take_sample(input logic [9:0] s);
    count_m = count_m + 17'd1;
    if (count_m >= thr_m) done_m = 1'b1;          // last sample still kept
    if (!low_res_m) begin
      store_word(s[7:0], {6'd0, s[9:8]});
    end else if (!half_m) begin
      pend_m = low_res_byte(s, lsb_m);
      half_m = 1'b1;
    end else begin
      store_word(pend_m, low_res_byte(s, lsb_m));
      half_m = 1'b0;
    end
  endtask

  task automatic compare(input string what, input logic [7:0] expected);
    if (reg_datao !== expected) begin
      value_errors++;
      $display("Fail reg_datao %s at addr 0x%02h lane %0d: expected 0x%02h, actual 0x%02h",
               what, reg_address, reg_bytecnt, expected, reg_datao);
    end
  endtask

  // mid-cycle, inputs and combinational read data settled
  always @(negedge clk_usb) begin
    if (reset) begin
      stream_q.delete();
      low_res_m = 1'b0;
      lsb_m     = 1'b0;
      half_m    = 1'b0;
      done_m    = 1'b0;
      count_m   = '0;
      thr_m     = 17'(`THRESHOLD_RESET);
    end else begin
      if (reg_write) begin
        case (reg_address)
          `ADC_LOW_RES: begin
            low_res_m = reg_datai[0];
            lsb_m     = reg_datai[1];
          end
          `STREAM_SEGMENT_THRESHOLD: begin
            if (reg_bytecnt == 0) thr_m[7:0] = reg_datai;
            if (reg_bytecnt == 1) thr_m[15:8] = reg_datai;
            if (reg_bytecnt == 2) thr_m[16] = reg_datai[0];
          end
          `FIFO_STAT: begin
            if (reg_datai[0]) begin               // rearm capture
              count_m = '0;
              done_m  = 1'b0;
              half_m  = 1'b0;
            end
          end
          default: ;
        endcase
      end
      if (sample_valid && !done_m) take_sample(adc_sample);
      if (!reg_read) begin
        compare("idle", 8'h00);
      end else if (chk_mode == 2'd1) begin
        compare("readback", exp_byte);
      end else if (chk_mode == 2'd2) begin
        if (stream_q.size() == 0) begin
          other_errors++;
          $display("stream read at %0t found no captured byte left in the model", $time);
        end else begin
          compare("stream byte", stream_q.pop_front());
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_adcfifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "adcfifo_config.svh"

module tb_adcfifo;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_STREAM, OP_EMPTY, OP_BURST, OP_IDLE} op_e;

  localparam int CLK_NS   = 40;
  localparam int MAX_ROWS = 80;

  logic                     clk_usb;
  logic                     reset;
  logic [7:0]               reg_address;
  logic [`BYTECNT_SIZE-1:0] reg_bytecnt;
  logic [7:0]               reg_datai;
  wire  [7:0]               reg_datao;
  logic                     reg_read;
  logic                     reg_write;
  logic [9:0]               adc_sample;
  logic                     sample_valid;
  logic [1:0]               chk_mode;              // 0 none, 1 table byte, 2 model stream
  logic [7:0]               exp_byte;
  wire  [31:0]              value_errors;
  wire  [31:0]              other_errors;

  op_e         row_op   [MAX_ROWS];
  logic [7:0]  row_addr [MAX_ROWS];
  logic [1:0]  row_lane [MAX_ROWS];
  logic [7:0]  row_val  [MAX_ROWS];                // write data or expected byte
  int          row_cnt  [MAX_ROWS];
  int          n_rows;
  int          total_cycles;                       // sizes the watchdog
  logic        table_ready;
  logic [31:0] lfsr;

  openadc_fifo_top dut_i (
    .clk_usb, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
    .reg_read, .reg_write, .adc_sample, .sample_valid
  );

  adcfifo_checker checker_i (
    .clk_usb, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
    .reg_read, .reg_write, .adc_sample, .sample_valid, .chk_mode, .exp_byte,
    .value_errors, .other_errors
  );

  initial begin
    clk_usb = 1'b0;
    forever #(CLK_NS / 2) clk_usb = ~clk_usb;
  end

  // galois form, shift right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  task automatic next_sample(output logic [9:0] s);
    s = '0;
    repeat (10) begin
      lfsr = lfsr_next(lfsr);
      s    = {s[8:0], lfsr[0]};                    // one step per bit
    end
  endtask

  task automatic step_cycle();
    @(posedge clk_usb);
    #2;                                            // drive just after the edge
  endtask

  task automatic add_row(input op_e op, input logic [7:0] addr, input logic [1:0] lane,
                         input logic [7:0] val, input int cnt);
    row_op[n_rows]   = op;
    row_addr[n_rows] = addr;
    row_lane[n_rows] = lane;
    row_val[n_rows]  = val;
    row_cnt[n_rows]  = cnt;
    n_rows++;
    case (op)
      OP_WRITE, OP_READ:  total_cycles += 2;
      OP_STREAM, OP_EMPTY: total_cycles += 2 * cnt;  // read plus idle each
      OP_BURST:           total_cycles += cnt + 1;
      default:            total_cycles += cnt;
    endcase
  endtask

  // one strobe cycle, then one idle cycle
  task automatic bus_cycle(input logic wr, input logic rd, input logic [7:0] addr,
                           input logic [1:0] lane, input logic [7:0] data,
                           input logic [1:0] chk, input logic [7:0] expected);
    reg_address = addr;
    reg_bytecnt = {{(`BYTECNT_SIZE-2){1'b0}}, lane};
    reg_datai   = data;
    reg_write   = wr;
    reg_read    = rd;
    chk_mode    = chk;
    exp_byte    = expected;
    step_cycle();
    reg_write   = 1'b0;
    reg_read    = 1'b0;
    chk_mode    = 2'd0;
    step_cycle();
  endtask

  task automatic run_row(input int i);
    logic [9:0] s;
    case (row_op[i])
      OP_WRITE: bus_cycle(1'b1, 1'b0, row_addr[i], row_lane[i], row_val[i], 2'd0, 8'h00);
      OP_READ:  bus_cycle(1'b0, 1'b1, row_addr[i], row_lane[i], 8'h00, 2'd1, row_val[i]);
      OP_STREAM: repeat (row_cnt[i]) bus_cycle(1'b0, 1'b1, `ADCREAD_ADDR, 2'd0, 8'h00, 2'd2, 8'h00);
      OP_EMPTY:  repeat (row_cnt[i]) bus_cycle(1'b0, 1'b1, `ADCREAD_ADDR, 2'd0, 8'h00, 2'd0, 8'h00);
      OP_BURST: begin
        repeat (row_cnt[i]) begin
          next_sample(s);
          adc_sample   = s;
          sample_valid = 1'b1;                     // back to back samples
          step_cycle();
        end
        sample_valid = 1'b0;
        step_cycle();
      end
      default: repeat (row_cnt[i]) step_cycle();
    endcase
  endtask

  task automatic load_table();
    // reset values, then threshold 20 and control readback
    add_row(OP_READ,  `STREAM_SEGMENT_THRESHOLD, 0, 8'h00, 1);
    add_row(OP_READ,  `STREAM_SEGMENT_THRESHOLD, 1, 8'h00, 1);
    add_row(OP_READ,  `STREAM_SEGMENT_THRESHOLD, 2, 8'h01, 1);
    add_row(OP_READ,  `FAST_FIFO_READ_MODE,      0, 8'h00, 1);
    add_row(OP_WRITE, `STREAM_SEGMENT_THRESHOLD, 0, 8'h14, 1);
    add_row(OP_WRITE, `STREAM_SEGMENT_THRESHOLD, 1, 8'h00, 1);
    add_row(OP_WRITE, `STREAM_SEGMENT_THRESHOLD, 2, 8'h00, 1);
    add_row(OP_READ,  `STREAM_SEGMENT_THRESHOLD, 0, 8'h14, 1);
    add_row(OP_READ,  `STREAM_SEGMENT_THRESHOLD, 2, 8'h00, 1);
    add_row(OP_WRITE, `ADC_LOW_RES,              0, 8'h03, 1);
    add_row(OP_READ,  `ADC_LOW_RES,              0, 8'h03, 1);
    add_row(OP_WRITE, `ADC_LOW_RES,              0, 8'h00, 1);
    add_row(OP_WRITE, `FIFO_NO_UNDERFLOW_ERROR,  0, 8'h01, 1);
    add_row(OP_READ,  `FIFO_NO_UNDERFLOW_ERROR,  0, 8'h01, 1);
    // masked slow underflow
    add_row(OP_EMPTY, `ADCREAD_ADDR,             0, 8'h00, 2);
    add_row(OP_READ,  `FIFO_STAT,                0, 8'h00, 1);
    add_row(OP_READ,  `FIFO_UNDERFLOW_COUNT,     0, 8'h00, 1);
    add_row(OP_WRITE, `FIFO_NO_UNDERFLOW_ERROR,  0, 8'h00, 1);
    // full resolution, 30 offered, 20 kept
    add_row(OP_BURST, 8'h00,                     0, 8'h00, 30);
    add_row(OP_READ,  `CAPTURE_DONE,             0, 8'h01, 1);
    add_row(OP_STREAM, `ADCREAD_ADDR,            0, 8'h00, 40);
    add_row(OP_READ,  `FIFO_STAT,                1, 8'h02, 1);
    // low res, bits 9..2, odd tail
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h01, 1);
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h00, 1);
    add_row(OP_WRITE, `ADC_LOW_RES,              0, 8'h01, 1);
    add_row(OP_WRITE, `STREAM_SEGMENT_THRESHOLD, 0, 8'h07, 1);
    add_row(OP_BURST, 8'h00,                     0, 8'h00, 9);
    add_row(OP_READ,  `CAPTURE_DONE,             0, 8'h01, 1);
    add_row(OP_STREAM, `ADCREAD_ADDR,            0, 8'h00, 6);
    // low res, bits 7..0
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h01, 1);
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h00, 1);
    add_row(OP_WRITE, `ADC_LOW_RES,              0, 8'h03, 1);
    add_row(OP_BURST, 8'h00,                     0, 8'h00, 8);
    add_row(OP_STREAM, `ADCREAD_ADDR,            0, 8'h00, 6);
    add_row(OP_READ,  `FIFO_STAT,                1, 8'h02, 1);
    // fast reads, then dropped by another write
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h01, 1);
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h00, 1);
    add_row(OP_WRITE, `ADC_LOW_RES,              0, 8'h00, 1);
    add_row(OP_BURST, 8'h00,                     0, 8'h00, 7);
    add_row(OP_WRITE, `FAST_FIFO_READ_MODE,      0, 8'h01, 1);
    add_row(OP_READ,  `FAST_FIFO_READ_MODE,      0, 8'h01, 1);
    add_row(OP_STREAM, `ADCREAD_ADDR,            0, 8'h00, 14);
    add_row(OP_WRITE, `FIFO_NO_UNDERFLOW_ERROR,  0, 8'h00, 1);
    add_row(OP_READ,  `FAST_FIFO_READ_MODE,      0, 8'h00, 1);
    // unmasked underflow
    add_row(OP_EMPTY, `ADCREAD_ADDR,             0, 8'h00, 2);
    add_row(OP_READ,  `FIFO_STAT,                0, 8'h02, 1);
    add_row(OP_READ,  `FIFO_UNDERFLOW_COUNT,     0, 8'h01, 1);
    add_row(OP_READ,  `FIFO_FIRST_ERROR,         0, 8'h02, 1);
    // overflow with threshold 263, first error held through an underflow
    add_row(OP_WRITE, `STREAM_SEGMENT_THRESHOLD, 1, 8'h01, 1);
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h01, 1);
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h00, 1);
    add_row(OP_BURST, 8'h00,                     0, 8'h00, 70);
    add_row(OP_READ,  `FIFO_STAT,                0, 8'h01, 1);
    add_row(OP_READ,  `FIFO_FIRST_ERROR,         0, 8'h01, 1);
    add_row(OP_READ,  `FIFO_FIRST_ERROR_STATE,   0, 8'h04, 1);
    add_row(OP_READ,  `DEBUG_FIFO_READS_FREEZE,  0, 8'h23, 1);  // 35 pops before overflow
    add_row(OP_STREAM, `ADCREAD_ADDR,            0, 8'h00, 128);
    add_row(OP_EMPTY, `ADCREAD_ADDR,             0, 8'h00, 2);
    add_row(OP_READ,  `FIFO_STAT,                0, 8'h03, 1);
    add_row(OP_READ,  `FIFO_FIRST_ERROR,         0, 8'h01, 1);
    add_row(OP_READ,  `DEBUG_FIFO_READS,         0, 8'h64, 1);  // 35 + 64 + 1 pops
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h01, 1);
    add_row(OP_WRITE, `FIFO_STAT,                0, 8'h00, 1);
    add_row(OP_READ,  `FIFO_FIRST_ERROR,         0, 8'h00, 1);
  endtask

  initial begin
    reset        = 1'b1;
    reg_address  = 8'h00;
    reg_bytecnt  = '0;
    reg_datai    = 8'h00;
    reg_read     = 1'b0;
    reg_write    = 1'b0;
    adc_sample   = 10'd0;
    sample_valid = 1'b0;
    chk_mode     = 2'd0;
    exp_byte     = 8'h00;
    lfsr         = 32'h4895_42d8;
    n_rows       = 0;
    total_cycles = 0;
    table_ready  = 1'b0;
    load_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk_usb);
    #2;
    reset = 1'b0;
    step_cycle();
    for (int i = 0; i < n_rows; i++) run_row(i);
    step_cycle();
    $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog, table length plus reset and margin
  initial begin
    wait (table_ready === 1'b1);
    #((total_cycles + 10 + 100) * CLK_NS);
    $display("Timeout: the table did not finish in the expected number of cycles");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/adcfifo_pkg.sv
design/adcfifo_regs.sv
design/adc_sample_fifo.sv
design/adc_read_formatter.sv
design/openadc_fifo_top.sv
bench/adcfifo_checker.sv
bench/tb_adcfifo.sv

//--- Bender.yml
package:
  name: openadc_fifo

sources:
  - include_dirs:
      - design
    files:
      - design/adcfifo_pkg.sv
      - design/adcfifo_regs.sv
      - design/adc_sample_fifo.sv
      - design/adc_read_formatter.sv
      - design/openadc_fifo_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/adcfifo_checker.sv
      - bench/tb_adcfifo.sv
